// File: design/hdc_cmd_pkg.sv
package hdc_cmd_pkg;

    // host opcodes, one command per strobe
    typedef enum logic [2:0] {
        OP_NOP    = 3'd0,
        // write one item memory word
        OP_LOAD   = 3'd1,
        // set window_last, clear every core
        OP_CONFIG = 3'd2,
        // feed one symbol into every core
        OP_FEED   = 3'd3,
        // snapshot and stream the accumulators
        OP_DRAIN  = 3'd4
    } hdc_op_e;

    typedef struct packed {
        hdc_op_e     op;
        // restart the n-gram with this symbol
        logic        first;
        // target core of a load
        logic [7:0]  core_sel;
        // item address or symbol, taken modulo ITEM_DEPTH
        logic [15:0] addr;
        // load word; low 5 bits are window_last on a config
        logic [31:0] data;
    } hdc_cmd_t;

endpackage

// File: design/hdc_core_pkg.sv
package hdc_core_pkg;

    localparam int HV_WIDTH = 32;

    typedef logic [HV_WIDTH-1:0] hv_t;

    // broadcast from the decoder to every core
    typedef struct packed {
        logic        clear;
        // memory read strobe
        logic        feed;
        // accumulate strobe, one cycle after feed
        logic        exec;
        logic        exec_first;
        logic [15:0] addr;
        hv_t         wdata;
        logic [4:0]  window_last;
    } core_ctrl_t;

    typedef struct packed {
        logic [7:0] core;
        hv_t        value;
    } hdc_result_t;

    typedef enum logic {
        COLL_IDLE  = 1'b0,
        COLL_SHIFT = 1'b1
    } coll_state_e;

endpackage

// File: design/hdc_cmd_decoder.sv
`timescale 1ns/1ps

module hdc_cmd_decoder #(
    parameter int NUM_CORES  = 4,
    parameter int ITEM_DEPTH = 64
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cmd_valid,
    input  hdc_cmd_pkg::hdc_cmd_t    cmd,
    output hdc_core_pkg::core_ctrl_t ctrl,
    output logic [NUM_CORES-1:0]     load_we,
    output logic                     drain
);

    logic is_load;
    logic is_config;
    logic is_feed;
    logic is_drain;

    logic                     clear_q;
    logic                     feed_q;
    logic                     exec_q;
    logic                     exec_first_q;
    logic                     drain_q;
    logic [NUM_CORES-1:0]     load_we_q;
    logic [4:0]               window_last_q;
    logic                     first_q;
    logic [15:0]              addr_q;
    hdc_core_pkg::hv_t        wdata_q;

    always_comb begin
        is_load   = 1'b0;
        is_config = 1'b0;
        is_feed   = 1'b0;
        is_drain  = 1'b0;
        if (cmd_valid) begin
            case (cmd.op)
                hdc_cmd_pkg::OP_LOAD:   is_load   = 1'b1;
                hdc_cmd_pkg::OP_CONFIG: is_config = 1'b1;
                hdc_cmd_pkg::OP_FEED:   is_feed   = 1'b1;
                hdc_cmd_pkg::OP_DRAIN:  is_drain  = 1'b1;
                default: ;
            endcase
        end
    end

    // one-cycle pulses and the window register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clear_q       <= 1'b0;
            feed_q        <= 1'b0;
            exec_q        <= 1'b0;
            exec_first_q  <= 1'b0;
            drain_q       <= 1'b0;
            load_we_q     <= '0;
            window_last_q <= '0;
        end else begin
            clear_q      <= is_config;
            feed_q       <= is_feed;
            drain_q      <= is_drain;
            // second feed stage where the accumulate follows the read
            exec_q       <= feed_q;
            exec_first_q <= feed_q & first_q;
            // only core indices below NUM_CORES can match
            for (int i = 0; i < NUM_CORES; i++) begin
                load_we_q[i] <= is_load && (cmd.core_sel == 8'(i));
            end
            if (is_config) begin
                window_last_q <= cmd.data[4:0];
            end
        end
    end

    // payload captured with any command
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            first_q <= cmd.first;
            addr_q  <= cmd.addr & 16'(ITEM_DEPTH - 1);
            wdata_q <= cmd.data;
        end
    end

    always_comb begin
        ctrl.clear       = clear_q;
        ctrl.feed        = feed_q;
        ctrl.exec        = exec_q;
        ctrl.exec_first  = exec_first_q;
        ctrl.addr        = addr_q;
        ctrl.wdata       = wdata_q;
        ctrl.window_last = window_last_q;
    end

    assign load_we = load_we_q;
    assign drain   = drain_q;

endmodule

// File: design/hdc_encode_core.sv
`timescale 1ns/1ps

module hdc_encode_core #(
    parameter int ITEM_DEPTH = 64
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  hdc_core_pkg::core_ctrl_t ctrl,
    input  logic                     load_we,
    output hdc_core_pkg::hv_t        acc
);

    localparam int AW = $clog2(ITEM_DEPTH);

    // item memory, maps to block RAM
    hdc_core_pkg::hv_t item_mem [ITEM_DEPTH];

    hdc_core_pkg::hv_t hv_q;
    hdc_core_pkg::hv_t acc_q;
    logic [4:0]        perm_q;
    logic [AW-1:0]     mem_addr;

    // rotate right by amt
    function automatic hdc_core_pkg::hv_t rotr(input hdc_core_pkg::hv_t v,
                                               input logic [4:0] amt);
        logic [2*hdc_core_pkg::HV_WIDTH-1:0] dbl;
        dbl = {v, v} >> amt;
        return dbl[hdc_core_pkg::HV_WIDTH-1:0];
    endfunction

    assign mem_addr = ctrl.addr[AW-1:0];

    // write and read never coincide, one command per cycle
    always_ff @(posedge clk) begin
        if (load_we) begin
            item_mem[mem_addr] <= ctrl.wdata;
        end else if (ctrl.feed) begin
            hv_q <= item_mem[mem_addr];
        end
    end

    // permutation counter, wraps at window_last
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            perm_q <= '0;
        end else if (ctrl.clear) begin
            perm_q <= '0;
        end else if (ctrl.exec) begin
            if (perm_q == ctrl.window_last) begin
                perm_q <= '0;
            end else begin
                perm_q <= perm_q + 5'd1;
            end
        end
    end

    // rotate-xor accumulator
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q <= '0;
        end else if (ctrl.clear) begin
            acc_q <= '0;
        end else if (ctrl.exec) begin
            if (ctrl.exec_first) begin
                // new n-gram starts unrotated
                acc_q <= hv_q;
            end else begin
                acc_q <= acc_q ^ rotr(hv_q, perm_q);
            end
        end
    end

    assign acc = acc_q;

endmodule

// File: design/hdc_result_collector.sv
`timescale 1ns/1ps

module hdc_result_collector #(
    parameter int NUM_CORES = 4
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  drain,
    input  hdc_core_pkg::hv_t [NUM_CORES-1:0]     accs,
    output logic                                  result_valid,
    output hdc_core_pkg::hdc_result_t             result
);

    hdc_core_pkg::coll_state_e          state_q;
    logic [7:0]                         idx_q;
    hdc_core_pkg::hv_t [NUM_CORES-1:0]  shreg_q;

    // burst control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= hdc_core_pkg::COLL_IDLE;
            idx_q   <= '0;
        end else begin
            case (state_q)
                hdc_core_pkg::COLL_IDLE: begin
                    if (drain) begin
                        state_q <= hdc_core_pkg::COLL_SHIFT;
                        idx_q   <= '0;
                    end
                end
                hdc_core_pkg::COLL_SHIFT: begin
                    // drain during a burst is dropped
                    if (idx_q == 8'(NUM_CORES - 1)) begin
                        state_q <= hdc_core_pkg::COLL_IDLE;
                        idx_q   <= '0;
                    end else begin
                        idx_q <= idx_q + 8'd1;
                    end
                end
                default: begin
                    state_q <= hdc_core_pkg::COLL_IDLE;
                end
            endcase
        end
    end

    // snapshot on drain, then core 0 leaves first
    always_ff @(posedge clk) begin
        if (state_q == hdc_core_pkg::COLL_IDLE) begin
            if (drain) begin
                shreg_q <= accs;
            end
        end else begin
            shreg_q <= shreg_q >> hdc_core_pkg::HV_WIDTH;
        end
    end

    assign result_valid = (state_q == hdc_core_pkg::COLL_SHIFT);

    always_comb begin
        result.core  = idx_q;
        result.value = shreg_q[0];
    end

endmodule

// File: design/hdc_encoder.sv
`timescale 1ns/1ps

module hdc_encoder #(
    parameter int NUM_CORES  = 4,
    parameter int ITEM_DEPTH = 64
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cmd_valid,
    input  hdc_cmd_pkg::hdc_cmd_t     cmd,
    output logic                      result_valid,
    output hdc_core_pkg::hdc_result_t result
);

    hdc_core_pkg::core_ctrl_t          ctrl;
    logic [NUM_CORES-1:0]              load_we;
    logic                              drain;
    hdc_core_pkg::hv_t [NUM_CORES-1:0] accs;

    hdc_cmd_decoder #(
        .NUM_CORES  (NUM_CORES),
        .ITEM_DEPTH (ITEM_DEPTH)
    ) u_hdc_cmd_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .ctrl      (ctrl),
        .load_we   (load_we),
        .drain     (drain)
    );

    // one encode core per lane, control is shared
    for (genvar g = 0; g < NUM_CORES; g++) begin : g_core
        hdc_encode_core #(
            .ITEM_DEPTH (ITEM_DEPTH)
        ) u_hdc_encode_core (
            .clk     (clk),
            .rst_n   (rst_n),
            .ctrl    (ctrl),
            .load_we (load_we[g]),
            .acc     (accs[g])
        );
    end

    hdc_result_collector #(
        .NUM_CORES (NUM_CORES)
    ) u_hdc_result_collector (
        .clk          (clk),
        .rst_n        (rst_n),
        .drain        (drain),
        .accs         (accs),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

// File: tests/hdc_encoder_sva.sv
`timescale 1ns/1ps

module hdc_encoder_sva #(
    parameter int NUM_CORES = 4
) (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      result_valid,
    input hdc_core_pkg::hdc_result_t result
);

    // no output while reset is held
    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !result_valid)
        else $error("result_valid high during reset");

    // every burst opens with core 0
    a_burst_start: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(result_valid) |-> result.core == 8'd0)
        else $error("burst did not start with core 0");

    // burst keeps going until the last core
    a_burst_hold: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid && result.core != 8'(NUM_CORES - 1) |=> result_valid)
        else $error("burst ended before the last core");

    a_burst_end: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid && result.core == 8'(NUM_CORES - 1) |=> !result_valid)
        else $error("burst ran past the last core");

    // ascending core order inside a burst
    a_core_step: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid && $past(result_valid) |-> result.core == 8'($past(result.core) + 8'd1))
        else $error("core index did not step by one");

endmodule

bind hdc_result_collector hdc_encoder_sva #(
    .NUM_CORES (NUM_CORES)
) u_hdc_encoder_sva (
    .clk          (clk),
    .rst_n        (rst_n),
    .result_valid (result_valid),
    .result       (result)
);

// File: tests/hdc_encoder_tb.sv
`timescale 1ns/1ps

module hdc_encoder_tb;

    localparam int NUM_CORES   = 4;
    localparam int ITEM_DEPTH  = 64;
    localparam int CLK_PERIOD  = 100;
    localparam int RANDOM_CMDS = 400;
    localparam int CMD_COUNT   = NUM_CORES * ITEM_DEPTH + 64 + RANDOM_CMDS;
    // a drain with its gap and burst is the longest command
    localparam int WATCHDOG_NS = (CMD_COUNT * (NUM_CORES + 8) + 50) * CLK_PERIOD;

    logic                      clk;
    logic                      rst_n;
    logic                      cmd_valid;
    hdc_cmd_pkg::hdc_cmd_t     cmd;
    logic                      result_valid;
    hdc_core_pkg::hdc_result_t result;

    // reference model state
    hdc_core_pkg::hv_t         mdl_mem [NUM_CORES][ITEM_DEPTH];
    hdc_core_pkg::hv_t         mdl_acc [NUM_CORES];
    int                        mdl_perm [NUM_CORES];
    int                        mdl_win;
    int                        last_drain_edge;
    int                        edge_cnt;
    logic [31:0]               lcg_state;
    hdc_core_pkg::hdc_result_t exp_q [$];

    hdc_encoder #(
        .NUM_CORES  (NUM_CORES),
        .ITEM_DEPTH (ITEM_DEPTH)
    ) u_hdc_encoder (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .result_valid (result_valid),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    function automatic logic [31:0] rand_word();
        logic [15:0] hi;
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        hi = lcg_state[31:16];
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {hi, lcg_state[31:16]};
    endfunction

    function automatic hdc_core_pkg::hv_t rotate_right(input hdc_core_pkg::hv_t v, input int amt);
        hdc_core_pkg::hv_t r;
        for (int i = 0; i < hdc_core_pkg::HV_WIDTH; i++) begin
            r[i] = v[(i + amt) % hdc_core_pkg::HV_WIDTH];
        end
        return r;
    endfunction

    // expected accumulator after one exec
    function automatic hdc_core_pkg::hv_t ref_accumulate(input hdc_core_pkg::hv_t acc,
                                                         input hdc_core_pkg::hv_t hv,
                                                         input int perm, input logic first);
        if (first) begin
            return hv;
        end
        return acc ^ rotate_right(hv, perm);
    endfunction

    function automatic hdc_cmd_pkg::hdc_cmd_t make_cmd(input hdc_cmd_pkg::hdc_op_e op,
                                                       input logic first, input logic [7:0] sel,
                                                       input logic [15:0] addr,
                                                       input logic [31:0] data);
        hdc_cmd_pkg::hdc_cmd_t c;
        c.op       = op;
        c.first    = first;
        c.core_sel = sel;
        c.addr     = addr;
        c.data     = data;
        return c;
    endfunction

    task automatic stop_on_error();
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_result(input hdc_core_pkg::hdc_result_t got,
                                input hdc_core_pkg::hdc_result_t exp);
        if (got !== exp) begin
            $display("mismatch at %0d ns: core %0d value %h, expected core %0d value %h",
                     $time, got.core, got.value, exp.core, exp.value);
            stop_on_error();
        end
    endtask

    task automatic check_idle(input logic valid);
        if (valid !== 1'b0) begin
            $display("result_valid is high at %0d ns although no result is expected", $time);
            stop_on_error();
        end
    endtask

    task automatic model_apply(input hdc_cmd_pkg::hdc_cmd_t c);
        int a;
        int sample_edge;
        hdc_core_pkg::hdc_result_t r;
        a = int'(c.addr) % ITEM_DEPTH;
        sample_edge = edge_cnt + 1;
        case (c.op)
            hdc_cmd_pkg::OP_LOAD: begin
                if (int'(c.core_sel) < NUM_CORES) begin
                    mdl_mem[int'(c.core_sel)][a] = c.data;
                end
            end
            hdc_cmd_pkg::OP_CONFIG: begin
                mdl_win = int'(c.data[4:0]);
                for (int k = 0; k < NUM_CORES; k++) begin
                    mdl_acc[k]  = '0;
                    mdl_perm[k] = 0;
                end
            end
            hdc_cmd_pkg::OP_FEED: begin
                for (int k = 0; k < NUM_CORES; k++) begin
                    mdl_acc[k]  = ref_accumulate(mdl_acc[k], mdl_mem[k][a], mdl_perm[k], c.first);
                    mdl_perm[k] = (mdl_perm[k] == mdl_win) ? 0 : mdl_perm[k] + 1;
                end
            end
            hdc_cmd_pkg::OP_DRAIN: begin
                // collector busy for NUM_CORES edges after an accepted drain
                if (sample_edge - last_drain_edge >= NUM_CORES) begin
                    for (int k = 0; k < NUM_CORES; k++) begin
                        r.core  = 8'(k);
                        r.value = mdl_acc[k];
                        exp_q.push_back(r);
                    end
                    last_drain_edge = sample_edge;
                end
            end
            default: ;
        endcase
    endtask

    task automatic send_cmd(input hdc_cmd_pkg::hdc_cmd_t c);
        @(negedge clk);
        cmd_valid = 1'b1;
        cmd       = c;
        model_apply(c);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            cmd_valid = 1'b0;
            cmd       = '0;
        end
    endtask

    task automatic wait_results();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < NUM_CORES + 4) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("fewer results than expected: %0d still missing", exp_q.size());
            stop_on_error();
        end
    endtask

    task automatic drain_and_check();
        idle_cycles(2);
        send_cmd(make_cmd(hdc_cmd_pkg::OP_DRAIN, 1'b0, 8'd0, 16'd0, 32'd0));
        idle_cycles(1);
        wait_results();
    endtask

    // compares every cycle after reset
    initial begin
        hdc_core_pkg::hdc_result_t exp_r;
        @(posedge rst_n);
        forever begin
            @(negedge clk);
            if (exp_q.size() == 0) begin
                check_idle(result_valid);
            end else if (result_valid) begin
                exp_r = exp_q.pop_front();
                check_result(result, exp_r);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        stop_on_error();
    end

    initial begin
        logic [31:0] r;
        logic [15:0] sym;
        rst_n           = 1'b0;
        cmd_valid       = 1'b0;
        cmd             = '0;
        edge_cnt        = 0;
        last_drain_edge = -1000;
        lcg_state       = 32'hd4d2;
        mdl_win         = 0;
        for (int k = 0; k < NUM_CORES; k++) begin
            mdl_acc[k]  = '0;
            mdl_perm[k] = 0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        check_idle(result_valid);
        rst_n = 1'b1;

        $display("test 1: reset state and empty drain");
        idle_cycles(4);
        drain_and_check();

        $display("test 2: load every core, single first feed");
        for (int k = 0; k < NUM_CORES; k++) begin
            for (int a = 0; a < ITEM_DEPTH; a++) begin
                send_cmd(make_cmd(hdc_cmd_pkg::OP_LOAD, 1'b0, 8'(k), 16'(a), rand_word()));
            end
        end
        send_cmd(make_cmd(hdc_cmd_pkg::OP_FEED, 1'b1, 8'd0, 16'(rand_word()), 32'd0));
        drain_and_check();

        $display("test 3: window 2 with five back-to-back feeds");
        send_cmd(make_cmd(hdc_cmd_pkg::OP_CONFIG, 1'b0, 8'd0, 16'd0, 32'd2));
        for (int n = 0; n < 5; n++) begin
            send_cmd(make_cmd(hdc_cmd_pkg::OP_FEED, n == 0, 8'd0, 16'(rand_word()), 32'd0));
        end
        drain_and_check();

        $display("test 4: config clears, out-of-range loads ignored");
        send_cmd(make_cmd(hdc_cmd_pkg::OP_CONFIG, 1'b0, 8'd0, 16'd0, 32'd5));
        drain_and_check();
        sym = 16'(rand_word());
        send_cmd(make_cmd(hdc_cmd_pkg::OP_LOAD, 1'b0, 8'(NUM_CORES), sym, rand_word()));
        send_cmd(make_cmd(hdc_cmd_pkg::OP_LOAD, 1'b0, 8'hff, sym, rand_word()));
        send_cmd(make_cmd(hdc_cmd_pkg::OP_FEED, 1'b1, 8'd0, sym, 32'd0));
        drain_and_check();

        $display("test 5: drain during a burst is ignored");
        send_cmd(make_cmd(hdc_cmd_pkg::OP_FEED, 1'b0, 8'd0, 16'(rand_word()), 32'd0));
        idle_cycles(2);
        send_cmd(make_cmd(hdc_cmd_pkg::OP_DRAIN, 1'b0, 8'd0, 16'd0, 32'd0));
        send_cmd(make_cmd(hdc_cmd_pkg::OP_DRAIN, 1'b0, 8'd0, 16'd0, 32'd0));
        idle_cycles(1);
        wait_results();
        idle_cycles(NUM_CORES + 2);

        $display("test 6: random command stream");
        for (int n = 0; n < RANDOM_CMDS; n++) begin
            r = rand_word();
            if (r[31:28] < 4'd4) begin
                send_cmd(make_cmd(hdc_cmd_pkg::OP_LOAD, 1'b0, 8'(int'(r[15:0]) % (NUM_CORES + 2)),
                                  16'(rand_word()), rand_word()));
            end else if (r[31:28] == 4'd4) begin
                send_cmd(make_cmd(hdc_cmd_pkg::OP_CONFIG, 1'b0, 8'd0, 16'd0, rand_word()));
            end else if (r[31:28] < 4'd14) begin
                send_cmd(make_cmd(hdc_cmd_pkg::OP_FEED, r[27:26] == 2'b00, 8'd0,
                                  16'(rand_word()), 32'd0));
            end else if (r[31:28] == 4'd14) begin
                drain_and_check();
            end else begin
                idle_cycles(1);
            end
        end
        drain_and_check();
        idle_cycles(NUM_CORES + 2);

        if (exp_q.size() == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("%0d expected results never arrived", exp_q.size());
            stop_on_error();
        end
    end

endmodule

// File: hdc_encoder.f
design/hdc_cmd_pkg.sv
design/hdc_core_pkg.sv
design/hdc_cmd_decoder.sv
design/hdc_encode_core.sv
design/hdc_result_collector.sv
design/hdc_encoder.sv
tests/hdc_encoder_sva.sv
tests/hdc_encoder_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := hdc_encoder_tb
FILELIST  := hdc_encoder.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := tests failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
